// File: common/muldiv_pkg.sv
`default_nettype none

// shared definitions for the multiply/divide execute unit
package muldiv_pkg;

	// ========================================================================
	// widths and cycle counts
	// ========================================================================

	localparam int DATA_W = 32;

	// wait cycles between loading the multiplier operands and the capture edge
	localparam int MUL_WAIT = 3;

	// one quotient bit is produced per restoring step
	localparam int DIV_STEPS = 32;

	// one spare bit so a wrap of the step counter would be visible
	localparam int DIV_CNT_W = $clog2(DIV_STEPS) + 1;

	// ========================================================================
	// opcode and function code encodings
	// ========================================================================

	typedef logic [8:0] op_t;
	typedef logic [3:0] fn_t;

	// register-register form, the function code picks the operation
	localparam op_t OP_RR      = 9'h002;
	// immediate forms are always unsigned, the operand arrives at full width
	localparam op_t OP_MUL_IMM = 9'h03a;
	localparam op_t OP_DIV_IMM = 9'h03b;
	localparam op_t OP_MOD_IMM = 9'h03c;

	localparam fn_t FN_MUL  = 4'h0;
	localparam fn_t FN_MULS = 4'h1;
	localparam fn_t FN_DIV  = 4'h2;
	localparam fn_t FN_MOD  = 4'h3;
	localparam fn_t FN_DIVS = 4'h4;
	localparam fn_t FN_MODS = 4'h5;

	// modulus shares the divide kind, the result holds quotient and remainder
	typedef enum logic [1:0] {
		KIND_MUL     = 2'd0,
		KIND_DIV     = 2'd1,
		KIND_ILLEGAL = 2'd2
	} kind_t;

	// ========================================================================
	// stage payloads
	// ========================================================================

	typedef struct packed {
		op_t               op;
		fn_t               fn;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} muldiv_req_t;

	typedef struct packed {
		kind_t             kind;
		logic [DATA_W-1:0] aa;
		logic [DATA_W-1:0] bb;
		logic              res_sgn;
	} muldiv_op_t;

	// remainder sits in the upper half, quotient in the lower half
	typedef struct packed {
		logic [DATA_W-1:0] rem;
		logic [DATA_W-1:0] quo;
	} muldiv_qr_t;

	// the same word is read as a product or as a remainder/quotient pair
	typedef union packed {
		logic [2*DATA_W-1:0] p;
		muldiv_qr_t          qr;
	} muldiv_result_u;

	typedef struct packed {
		kind_t          kind;
		logic           res_sgn;
		logic           illegal;
		muldiv_result_u res;
	} muldiv_res_t;

endpackage

`default_nettype wire

// File: rtl/muldiv_decode.sv
`timescale 1ns/1ps
`default_nettype none

// decode stage of the multiply/divide unit
// classifies the request and turns signed operands into magnitudes
module muldiv_decode
	import muldiv_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	output logic        in_ready,
	input  muldiv_req_t in,
	output logic        dec_valid,
	input  logic        dec_ready,
	output muldiv_op_t  dec
);

	// high from the first clock after reset, keeps in_ready low during reset
	logic       live;
	logic       accept;
	logic       sgn_form;
	kind_t      kind;
	muldiv_op_t nxt;

	// the single entry can take a new request when empty or draining now
	assign in_ready = live & (~dec_valid | dec_ready);
	assign accept   = in_valid & in_ready;

	// ========================================================================
	// op/fn classification
	// ========================================================================

	always_comb
	begin
		kind     = KIND_ILLEGAL;
		sgn_form = 1'b0;
		case (in.op)
		OP_MUL_IMM:
			kind = KIND_MUL;
		OP_DIV_IMM, OP_MOD_IMM:
			kind = KIND_DIV;
		OP_RR:
			case (in.fn)
			FN_MUL:
				kind = KIND_MUL;
			FN_MULS:
			begin
				kind     = KIND_MUL;
				sgn_form = 1'b1;
			end
			FN_DIV, FN_MOD:
				kind = KIND_DIV;
			FN_DIVS, FN_MODS:
			begin
				kind     = KIND_DIV;
				sgn_form = 1'b1;
			end
			default:
				kind = KIND_ILLEGAL;
			endcase
		default:
			kind = KIND_ILLEGAL;
		endcase
	end

	// signed forms work on magnitudes, the sign is put back in the last stage
	// an illegal request carries zero operands so the result comes out zero
	always_comb
	begin
		nxt.kind    = kind;
		nxt.aa      = '0;
		nxt.bb      = '0;
		nxt.res_sgn = 1'b0;
		if (kind != KIND_ILLEGAL)
		begin
			nxt.aa      = (sgn_form && in.a[DATA_W-1]) ? -in.a : in.a;
			nxt.bb      = (sgn_form && in.b[DATA_W-1]) ? -in.b : in.b;
			nxt.res_sgn = sgn_form & (in.a[DATA_W-1] ^ in.b[DATA_W-1]);
		end
	end

	// ========================================================================
	// stage register
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			live      <= 1'b0;
			dec_valid <= 1'b0;
		end
		else
		begin
			live <= 1'b1;
			if (accept)
				dec_valid <= 1'b1;
			else if (dec_ready)
				dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			dec <= nxt;
	end

endmodule

`default_nettype wire

// File: muldiv_core/muldiv_exec.sv
`timescale 1ns/1ps
`default_nettype none

// execute stage of the multiply/divide unit
// a multiply with wait states or a restoring divide, one result register
module muldiv_exec
	import muldiv_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        dec_valid,
	output logic        dec_ready,
	input  muldiv_op_t  dec,
	output logic        ex_valid,
	input  logic        ex_ready,
	output muldiv_res_t ex
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT1,
		ST_WAIT2,
		ST_WAIT3,
		ST_CAPT,
		ST_DIV,
		ST_HOLD
	} state_t;

	state_t                state;
	logic                  accept;
	logic [DIV_CNT_W-1:0]  cnt;
	kind_t                 kind_r;
	logic                  sgn_r;
	logic [DATA_W-1:0]     opa;
	logic [DATA_W-1:0]     opb;
	logic [DATA_W-1:0]     rem_r;
	logic [DATA_W-1:0]     quo_r;
	logic [2*DATA_W-1:0]   prod;
	logic [DATA_W+1:0]     diff;
	logic [DATA_W-1:0]     rem_nxt;

	// new work only when idle, which also means the result register is free
	assign dec_ready = (state == ST_IDLE);
	assign ex_valid  = (state == ST_HOLD);
	assign accept    = dec_valid & dec_ready;

	// multicycle path: opa/opb stay put from load through the capture edge,
	// so this product gets MUL_WAIT+1 cycles to settle
	assign prod = opa * opb;

	// one restoring step: shift the next dividend bit into the partial
	// remainder and try to subtract the divisor, the top bit flags a borrow
	assign diff    = {1'b0, rem_r, quo_r[DATA_W-1]} - {2'b00, opb};
	assign rem_nxt = diff[DATA_W+1] ? {rem_r[DATA_W-2:0], quo_r[DATA_W-1]}
	                                : diff[DATA_W-1:0];

	// ========================================================================
	// control FSM
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
			ST_IDLE:
				if (accept)
				begin
					case (dec.kind)
					KIND_MUL:
						state <= ST_WAIT1;
					KIND_DIV:
					begin
						state <= ST_DIV;
						cnt   <= DIV_CNT_W'(DIV_STEPS - 1);
					end
					// illegal requests skip straight to the result register
					default:
						state <= ST_HOLD;
					endcase
				end
			ST_WAIT1:
				state <= ST_WAIT2;
			ST_WAIT2:
				state <= ST_WAIT3;
			ST_WAIT3:
				state <= ST_CAPT;
			ST_DIV:
				if (cnt == '0)
					state <= ST_CAPT;
				else
					cnt <= cnt - 1'b1;
			ST_CAPT:
				state <= ST_HOLD;
			ST_HOLD:
				if (ex_ready)
					state <= ST_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// ========================================================================
	// datapath
	// ========================================================================

	always_ff @(posedge clk)
	begin
		case (state)
		ST_IDLE:
			if (accept)
			begin
				opa    <= dec.aa;
				opb    <= dec.bb;
				kind_r <= dec.kind;
				sgn_r  <= dec.res_sgn;
				// the quotient register starts out holding the dividend
				rem_r  <= '0;
				quo_r  <= dec.aa;
				if (dec.kind == KIND_ILLEGAL)
				begin
					ex.kind    <= KIND_ILLEGAL;
					ex.res_sgn <= 1'b0;
					ex.illegal <= 1'b1;
					ex.res     <= '0;
				end
			end
		ST_DIV:
		begin
			rem_r <= rem_nxt;
			quo_r <= {quo_r[DATA_W-2:0], ~diff[DATA_W+1]};
		end
		ST_CAPT:
		begin
			ex.kind    <= kind_r;
			ex.res_sgn <= sgn_r;
			ex.illegal <= 1'b0;
			if (kind_r == KIND_MUL)
				ex.res.p <= prod;
			else
			begin
				ex.res.qr.rem <= rem_r;
				ex.res.qr.quo <= quo_r;
			end
		end
		default:
			;
		endcase
	end

	// the counter is wide enough that a wrap would read back above the step count
	a_div_cnt: assert property (@(posedge clk) disable iff (rst)
		(state == ST_DIV) |-> (cnt < DIV_CNT_W'(DIV_STEPS)));

	a_ex_stable: assert property (@(posedge clk) disable iff (rst)
		(ex_valid && !ex_ready) |=> (ex_valid && $stable(ex)));

endmodule

`default_nettype wire

// File: rtl/muldiv_sign_fix.sv
`timescale 1ns/1ps
`default_nettype none

// last stage of the multiply/divide unit
// puts the sign back on magnitude results and drives the output handshake
module muldiv_sign_fix
	import muldiv_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        ex_valid,
	output logic        ex_ready,
	input  muldiv_res_t ex,
	output logic        out_valid,
	input  logic        out_ready,
	output muldiv_res_t out
);

	muldiv_res_t fixed;
	logic        accept;

	// one entry, refilled in the same cycle it is drained
	assign ex_ready = ~out_valid | out_ready;
	assign accept   = ex_valid & ex_ready;

	// ========================================================================
	// sign correction
	// ========================================================================

	// the union is read by kind: a product negates as one 64-bit value,
	// quotient and remainder negate as two separate halves
	always_comb
	begin
		fixed         = ex;
		fixed.illegal = (ex.kind == KIND_ILLEGAL);
		if (ex.res_sgn)
		begin
			case (ex.kind)
			KIND_MUL:
				fixed.res.p = -ex.res.p;
			KIND_DIV:
			begin
				fixed.res.qr.quo = -ex.res.qr.quo;
				fixed.res.qr.rem = -ex.res.qr.rem;
			end
			default:
				fixed.res = ex.res;
			endcase
		end
	end

	// ========================================================================
	// output register
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// res_sgn is left in the output word for tracing only
	always_ff @(posedge clk)
	begin
		if (accept)
			out <= fixed;
	end

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out)));

endmodule

`default_nettype wire

// File: rtl/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

// multiply/divide execute unit
// decode, execute and sign fix joined by valid/ready links
module muldiv_top
	import muldiv_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	output logic        in_ready,
	input  muldiv_req_t in,
	output logic        out_valid,
	input  logic        out_ready,
	output muldiv_res_t out
);

	// decode to execute
	logic        dec_valid;
	logic        dec_ready;
	muldiv_op_t  dec;

	// execute to sign fix
	logic        ex_valid;
	logic        ex_ready;
	muldiv_res_t ex;

	muldiv_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in        (in),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec       (dec)
	);

	muldiv_exec u_exec (
		.clk       (clk),
		.rst       (rst),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec       (dec),
		.ex_valid  (ex_valid),
		.ex_ready  (ex_ready),
		.ex        (ex)
	);

	muldiv_sign_fix u_sign_fix (
		.clk       (clk),
		.rst       (rst),
		.ex_valid  (ex_valid),
		.ex_ready  (ex_ready),
		.ex        (ex),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out)
	);

endmodule

`default_nettype wire

// File: tests/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the multiply/divide unit
// random requests go in with gaps, results come out under random back-pressure
module muldiv_tb
	import muldiv_pkg::*;
;

	localparam int NUM_REQ     = 400;
	localparam int SEED        = 58664;
	// a divide needs about 35 cycles in the execute stage, 40 leaves slack
	localparam int CYC_PER_REQ = 40;
	localparam int TIMEOUT_NS  = (NUM_REQ * CYC_PER_REQ + 1000) * 10;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic        in_ready;
	muldiv_req_t in;
	logic        out_valid;
	logic        out_ready;
	muldiv_res_t out;

	// expected results in issue order
	muldiv_res_t exp_q[$];
	muldiv_res_t held_out;
	bit          stall_pending;
	int          issued;
	int          accepted;
	int          received;
	int          mism_errs;
	int          stall_errs;
	int          other_errs;

	muldiv_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in        (in),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out)
	);

	initial
		clk = 1'b0;

	always #5 clk = ~clk;

	// ========================================================================
	// reference model
	// ========================================================================

	// expected output word for one request, built from the unit's rules
	function automatic muldiv_res_t model_result(input muldiv_req_t r);
		muldiv_res_t e;
		logic        legal;
		logic        is_mul;
		logic        sgn_form;
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] quo;
		logic [31:0] rem;
		e        = '0;
		legal    = 1'b1;
		is_mul   = 1'b0;
		sgn_form = 1'b0;
		if (r.op == OP_MUL_IMM)
			is_mul = 1'b1;
		else if (r.op == OP_DIV_IMM || r.op == OP_MOD_IMM)
			is_mul = 1'b0;
		else if (r.op == OP_RR && (r.fn == FN_MUL || r.fn == FN_MULS))
		begin
			is_mul   = 1'b1;
			sgn_form = (r.fn == FN_MULS);
		end
		else if (r.op == OP_RR && r.fn inside {FN_DIV, FN_MOD, FN_DIVS, FN_MODS})
			sgn_form = (r.fn == FN_DIVS || r.fn == FN_MODS);
		else
			legal = 1'b0;
		if (!legal)
		begin
			// an unknown code yields a zero result with the flag raised
			e.kind    = KIND_ILLEGAL;
			e.illegal = 1'b1;
		end
		else if (is_mul)
		begin
			e.kind    = KIND_MUL;
			e.res_sgn = sgn_form & (r.a[31] ^ r.b[31]);
			// sign-extended operands give the signed product modulo 2^64
			if (sgn_form)
				e.res.p = {{32{r.a[31]}}, r.a} * {{32{r.b[31]}}, r.b};
			else
				e.res.p = {32'h0, r.a} * {32'h0, r.b};
		end
		else
		begin
			e.kind    = KIND_DIV;
			e.res_sgn = sgn_form & (r.a[31] ^ r.b[31]);
			ma        = (sgn_form && r.a[31]) ? 32'h0 - r.a : r.a;
			mb        = (sgn_form && r.b[31]) ? 32'h0 - r.b : r.b;
			// a zero divisor leaves all ones in the quotient and the dividend behind
			if (mb == 32'h0)
			begin
				quo = 32'hffff_ffff;
				rem = ma;
			end
			else
			begin
				quo = ma / mb;
				rem = ma % mb;
			end
			if (e.res_sgn)
			begin
				quo = 32'h0 - quo;
				rem = 32'h0 - rem;
			end
			e.res.qr.quo = quo;
			e.res.qr.rem = rem;
		end
		return e;
	endfunction

	// ========================================================================
	// stimulus generation
	// ========================================================================

	// extremes show up often so sign edges and zero divisors get exercised
	function automatic logic [31:0] pick_operand();
		logic [31:0] v;
		case ($urandom_range(7))
		0:       v = 32'h0000_0000;
		1:       v = 32'h8000_0000;
		2:       v = 32'h7fff_ffff;
		3:       v = 32'hffff_ffff;
		4:       v = $urandom_range(15);
		default: v = $urandom;
		endcase
		return v;
	endfunction

	function automatic muldiv_req_t make_request();
		muldiv_req_t r;
		r.a  = pick_operand();
		r.b  = pick_operand();
		r.fn = fn_t'($urandom_range(5));
		case ($urandom_range(9))
		0:       r.op = OP_MUL_IMM;
		1:       r.op = OP_DIV_IMM;
		2:       r.op = OP_MOD_IMM;
		// any function code, the unused ones are illegal
		3:
		begin
			r.op = OP_RR;
			r.fn = fn_t'($urandom_range(15));
		end
		// a random opcode almost never hits a legal one
		4:       r.op = op_t'($urandom);
		default: r.op = OP_RR;
		endcase
		if ($urandom_range(9) == 3)
			r.op = OP_RR;
		return r;
	endfunction

	// ========================================================================
	// output checks
	// ========================================================================

	task automatic check_output(input muldiv_res_t got);
		muldiv_res_t exp;
		assert (exp_q.size() != 0)
		else
		begin
			other_errs++;
			$display("output transfer at %0t with no request outstanding", $time);
		end
		if (exp_q.size() != 0)
		begin
			exp = exp_q.pop_front();
			assert (got.kind == exp.kind)
			else
			begin
				mism_errs++;
				$display("mismatch out.kind: expected %h got %h (result %0d)",
					exp.kind, got.kind, received);
			end
			assert (got.illegal == exp.illegal)
			else
			begin
				mism_errs++;
				$display("mismatch out.illegal: expected %h got %h (result %0d)",
					exp.illegal, got.illegal, received);
			end
			assert (got.res_sgn == exp.res_sgn)
			else
			begin
				mism_errs++;
				$display("mismatch out.res_sgn: expected %h got %h (result %0d)",
					exp.res_sgn, got.res_sgn, received);
			end
			assert (got.res == exp.res)
			else
			begin
				mism_errs++;
				$display("mismatch out.res: expected %h got %h (result %0d)",
					exp.res, got.res, received);
			end
			received++;
		end
	endtask

	// inputs change on the falling edge, so both links are steady here
	always @(posedge clk)
	begin
		if (!rst)
		begin
			// a stalled output must stay valid and keep its value
			if (stall_pending)
			begin
				assert (out_valid)
				else
				begin
					stall_errs++;
					$display("out_valid dropped at %0t before the output was taken", $time);
				end
				assert (out == held_out)
				else
				begin
					stall_errs++;
					$display("mismatch out while stalled: expected %h got %h", held_out, out);
				end
			end
			stall_pending = out_valid && !out_ready;
			held_out      = out;
			if (in_valid && in_ready)
			begin
				exp_q.push_back(model_result(in));
				accepted++;
			end
			if (out_valid && out_ready)
				check_output(out);
		end
	end

	// ========================================================================
	// main sequence
	// ========================================================================

	initial
	begin
		void'($urandom(SEED));
		rst       = 1'b1;
		in_valid  = 1'b0;
		in        = '0;
		out_ready = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// issue all requests with random gaps, out_ready low about 40% of cycles
		while (issued < NUM_REQ || in_valid)
		begin
			@(negedge clk);
			out_ready = ($urandom_range(99) >= 40);
			if (in_valid && accepted == issued)
				in_valid = 1'b0;
			if (!in_valid && issued < NUM_REQ && $urandom_range(3) != 0)
			begin
				in       = make_request();
				in_valid = 1'b1;
				issued++;
			end
		end
		while (received < NUM_REQ)
		begin
			@(negedge clk);
			out_ready = ($urandom_range(99) >= 40);
		end
		// let any stray extra output show up
		out_ready = 1'b1;
		repeat (40) @(negedge clk);
		$display("summary: %0d results checked, %0d mismatch, %0d stall, %0d other errors",
			received, mism_errs, stall_errs, other_errs);
		if (mism_errs + stall_errs + other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// watchdog against a stuck handshake
	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns with %0d of %0d results received",
			TIMEOUT_NS, received, NUM_REQ);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: muldiv.f
common/muldiv_pkg.sv
rtl/muldiv_decode.sv
muldiv_core/muldiv_exec.sv
rtl/muldiv_sign_fix.sv
rtl/muldiv_top.sv
tests/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the multiply/divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--top-module muldiv_tb \
	-f muldiv.f \
	-o muldiv_sim

./obj_dir/muldiv_sim 2>&1 | tee "$LOG"

# the testbench prints the fail line on any error or timeout
if grep -q "=== FAIL ===" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0
